// ==== Makefile ====
# Verilator build and run for the colour mixer testbench

VERILATOR ?= verilator
TOP       ?= colmix_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "test FAILED, exit status $$status"; exit 1; fi; \
	echo "test done"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+logic
logic/colmix_pkg.sv
logic/cfg_wr_if.sv
logic/colmix_apb_regs.sv
logic/prio_table.sv
logic/palette_ram.sv
logic/blank_delay.sv
logic/colmix_core.sv
logic/colmix_top.sv
verif/colmix_props.sv
verif/colmix_tb.sv

// ==== logic/blank_delay.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// blanking delay line
// shifts {hblank_n, vblank_n} by STAGES pixel periods
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module blank_delay #(
    parameter int STAGES = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic [1:0] din,
    output logic [1:0] dout
);

    logic [1:0] sh [STAGES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++)
                sh[i] <= 2'b00;          // out of reset we are blanking
        end else if (cen) begin
            sh[0] <= din;
            for (int i = 1; i < STAGES; i++)
                sh[i] <= sh[i-1];
        end
    end

    assign dout = sh[STAGES-1];

endmodule

// ==== logic/cfg_wr_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table write bus
// carries palette and priority table writes from the APB block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

interface cfg_wr_if;

    colmix_pkg::reg_addr_t     wr_addr;  // offset inside the selected region
    logic [`COLMIX_DATA_W-1:0] wr_data;
    logic                      rg_we;    // one clk pulse each, never two at once
    logic                      b_we;
    logic                      prio_we;

    modport source (output wr_addr, wr_data, rg_we, b_we, prio_we);
    modport sink   (input  wr_addr, wr_data, rg_we, b_we, prio_we);

endinterface

// ==== logic/colmix_apb_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register block
// decodes the word map, issues table writes, holds layer enables
// no wait states, unmapped accesses end with pslverr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module colmix_apb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  colmix_pkg::reg_addr_t     paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`COLMIX_DATA_W-1:0] pwdata,
    output logic [`COLMIX_DATA_W-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    cfg_wr_if.source                  wr,
    output colmix_pkg::layer_en_t     layer_en
);

    localparam colmix_pkg::reg_addr_t PAL_SIZE  = colmix_pkg::reg_addr_t'(1 << `COLMIX_PAL_AW);
    localparam colmix_pkg::reg_addr_t PRIO_SIZE = colmix_pkg::reg_addr_t'(1 << `COLMIX_PRIO_AW);

    colmix_pkg::apb_state_t state;
    colmix_pkg::reg_addr_t  off_rg, off_b, off_prio;
    logic                   hit_rg, hit_b, hit_prio, hit_ctrl;
    logic                   access;   // access phase of a transfer that had its setup
    logic                   bad;

    // region offsets, below-base addresses wrap high and miss
    assign off_rg   = paddr - `COLMIX_RG_BASE;
    assign off_b    = paddr - `COLMIX_B_BASE;
    assign off_prio = paddr - `COLMIX_PRIO_BASE;

    assign hit_rg   = off_rg   < PAL_SIZE;
    assign hit_b    = off_b    < PAL_SIZE;
    assign hit_prio = off_prio < PRIO_SIZE;
    assign hit_ctrl = paddr == `COLMIX_CTRL_ADDR;

    assign access = (state == colmix_pkg::ST_SETUP) && psel && penable;
    // tables are write only, so only ctrl reads back
    assign bad    = pwrite ? !(hit_rg || hit_b || hit_prio || hit_ctrl) : !hit_ctrl;

    assign pready  = 1'b1;                              // never stretch a transfer
    assign pslverr = access && bad;
    assign prdata  = (access && !pwrite && hit_ctrl) ?
                     `COLMIX_DATA_W'(layer_en) : '0;

    // phase tracker, moves on the edge that closes each phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= colmix_pkg::ST_IDLE;
        end else begin
            case (state)
                colmix_pkg::ST_SETUP:
                    state <= access ? colmix_pkg::ST_ACCESS
                           : (psel && !penable) ? colmix_pkg::ST_SETUP
                           : colmix_pkg::ST_IDLE;
                default:    // idle or access, look for a new setup
                    state <= (psel && !penable) ? colmix_pkg::ST_SETUP : colmix_pkg::ST_IDLE;
            endcase
        end
    end

    // write strobes, registered so tables update the clk after access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.rg_we   <= 1'b0;
            wr.b_we    <= 1'b0;
            wr.prio_we <= 1'b0;
            layer_en   <= `COLMIX_CTRL_RST;
        end else begin
            wr.rg_we   <= access && pwrite && hit_rg;
            wr.b_we    <= access && pwrite && hit_b;
            wr.prio_we <= access && pwrite && hit_prio;
            if (access && pwrite && hit_ctrl)
                layer_en <= pwdata[2:0];
        end
    end

    // write payload, only meaningful alongside a strobe
    always_ff @(posedge clk) begin
        wr.wr_data <= pwdata;
        wr.wr_addr <= hit_rg ? off_rg : hit_b ? off_b : off_prio;
    end

endmodule

// ==== logic/colmix_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixing pipeline
// opacity tests -> priority lookup -> layer select -> palette
// -> blanked RGB, three pix_cen samples deep
// pix_cen must leave an idle clk for the table and palette reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module colmix_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_cen,
    input  colmix_pkg::char_pxl_t char_pxl,
    input  colmix_pkg::scr_pxl_t  scr_pxl,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    input  colmix_pkg::layer_en_t layer_en,
    input  logic                  hblank_n,
    input  logic                  vblank_n,
    cfg_wr_if.sink                wr,
    output colmix_pkg::color4_t   red,
    output colmix_pkg::color4_t   green,
    output colmix_pkg::color4_t   blue,
    output logic                  hblank_n_dly,
    output logic                  vblank_n_dly
);

    logic                   char_opq, obj_opq;
    logic [1:0]             scr_prio;
    colmix_pkg::prio_addr_t s1_addr;
    colmix_pkg::char_pxl_t  s1_char;
    colmix_pkg::scr_pxl_t   s1_scr;
    colmix_pkg::obj_pxl_t   s1_obj;
    colmix_pkg::prio_sel_t  sel;
    colmix_pkg::scr_pxl_t   code;       // chosen layer code, zero extended
    colmix_pkg::pal_idx_t   s2_idx;
    colmix_pkg::color4_t    pal_r, pal_g, pal_b;
    logic [1:0]             blank_n;    // {h, v} two samples late
    logic                   blanking;

    // stage 1, table address {char, obj, scroll prio, scroll code}
    assign char_opq = ~&char_pxl[1:0] & layer_en[0];
    assign obj_opq  = ~&obj_pxl[3:0]  & layer_en[2];
    assign scr_prio = (scr_pxl[7] || !layer_en[1]) ? 2'd0
                    : scr_pxl[6:5] + 2'd1;               // 3 wraps to 0

    always_ff @(posedge clk) begin
        if (pix_cen) begin
            s1_addr <= {char_opq, obj_opq, scr_prio, scr_pxl[3:0]};
            s1_char <= char_pxl;
            s1_scr  <= scr_pxl;
            s1_obj  <= obj_pxl;
        end
    end

    prio_table i_prio (
        .clk     (clk),
        .addr    (s1_addr),
        .sel     (sel),                                  // valid one clk after s1
        .wr_addr (wr.wr_addr[`COLMIX_PRIO_AW-1:0]),
        .wr_data (wr.wr_data[3:0]),
        .we      (wr.prio_we)
    );

    // stage 2, pick the winning layer
    always_comb begin
        case (sel[1:0])
            2'd3:    code = colmix_pkg::scr_pxl_t'(s1_char);
            2'd2:    code = s1_scr;
            2'd1:    code = colmix_pkg::scr_pxl_t'(s1_obj);
            default: code = '0;                          // nothing opaque
        endcase
    end

    always_ff @(posedge clk) begin
        if (pix_cen)
            s2_idx <= {sel[3:2], code};                  // bank picks a palette quarter
    end

    palette_ram #(.DW(8)) i_pal_rg (
        .clk     (clk),
        .rd_idx  (s2_idx),
        .q       ({pal_r, pal_g}),
        .wr_idx  (wr.wr_addr[`COLMIX_PAL_AW-1:0]),
        .wr_data (wr.wr_data),
        .we      (wr.rg_we)
    );

    palette_ram #(.DW(4)) i_pal_b (
        .clk     (clk),
        .rd_idx  (s2_idx),
        .q       (pal_b),
        .wr_idx  (wr.wr_addr[`COLMIX_PAL_AW-1:0]),
        .wr_data (wr.wr_data[3:0]),
        .we      (wr.b_we)
    );

    // blanks run two samples here, the output register adds the third
    blank_delay #(.STAGES(`COLMIX_PIPE_DEPTH - 1)) i_blank (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (pix_cen),
        .din   ({hblank_n, vblank_n}),
        .dout  (blank_n)
    );

    assign blanking = !blank_n[1] || !blank_n[0];

    // stage 3, colour and delayed blanks leave together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {red, green, blue} <= '0;
            hblank_n_dly       <= 1'b0;
            vblank_n_dly       <= 1'b0;
        end else if (pix_cen) begin
            {red, green, blue} <= blanking ? 12'd0 : {pal_r, pal_g, pal_b};
            hblank_n_dly       <= blank_n[1];
            vblank_n_dly       <= blank_n[0];
        end
    end

endmodule

// ==== logic/colmix_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer types
// pixel codes, palette and table addresses, APB phase enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "colmix_settings.svh"

package colmix_pkg;

    typedef logic [`COLMIX_CHAR_W-1:0]  char_pxl_t;   // char code, 2'b11 in 1:0 is clear
    typedef logic [`COLMIX_SCR_W-1:0]   scr_pxl_t;    // scroll code
    typedef logic [`COLMIX_OBJ_W-1:0]   obj_pxl_t;    // object code, 4'hf in 3:0 is clear

    typedef logic [`COLMIX_PAL_AW-1:0]  pal_idx_t;
    typedef logic [`COLMIX_PRIO_AW-1:0] prio_addr_t;

    // bank in 3:2, layer in 1:0 (3 char, 2 scroll, 1 object, 0 none)
    typedef logic [3:0]                 prio_sel_t;

    typedef logic [3:0]                 color4_t;
    typedef logic [2:0]                 layer_en_t;   // bit 0 char, 1 scroll, 2 object
    typedef logic [`COLMIX_ADDR_W-1:0]  reg_addr_t;

    // last bus phase seen by the register block
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } apb_state_t;

endpackage

// ==== logic/colmix_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer settings
// layer widths, table sizes, pipeline depth and APB address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COLMIX_SETTINGS_SVH
`define COLMIX_SETTINGS_SVH

`define COLMIX_CHAR_W     7        // character layer code
`define COLMIX_SCR_W      8        // scroll layer code, bit 7 forces low priority
`define COLMIX_OBJ_W      7        // object layer code
`define COLMIX_PAL_AW     10       // palette index, 2 bank bits + 8 code bits
`define COLMIX_PRIO_AW    8        // priority table address
`define COLMIX_PIPE_DEPTH 3        // pix_cen samples from input to colour
`define COLMIX_ADDR_W     12       // APB word address
`define COLMIX_DATA_W     8        // APB data bus

// word address map
`define COLMIX_RG_BASE    12'h000  // red in 7:4, green in 3:0
`define COLMIX_B_BASE     12'h400  // blue in 3:0
`define COLMIX_PRIO_BASE  12'h800  // 256 entries of {bank, layer}
`define COLMIX_CTRL_ADDR  12'hC00  // layer enables, obj/scr/char in 2:0
`define COLMIX_CTRL_RST   3'b111

`endif

// ==== logic/colmix_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer top
// APB register block plus the pixel mixing core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module colmix_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // APB
    input  colmix_pkg::reg_addr_t     paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`COLMIX_DATA_W-1:0] pwdata,
    output logic [`COLMIX_DATA_W-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    // video
    input  logic                      pix_cen,
    input  colmix_pkg::char_pxl_t     char_pxl,
    input  colmix_pkg::scr_pxl_t      scr_pxl,
    input  colmix_pkg::obj_pxl_t      obj_pxl,
    input  logic                      hblank_n,
    input  logic                      vblank_n,
    output colmix_pkg::color4_t       red,
    output colmix_pkg::color4_t       green,
    output colmix_pkg::color4_t       blue,
    output logic                      hblank_n_dly,
    output logic                      vblank_n_dly
);

    colmix_pkg::layer_en_t layer_en;

    cfg_wr_if i_wr ();        // table writes, regs -> core

    colmix_apb_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .wr       (i_wr.source),
        .layer_en (layer_en)
    );

    colmix_core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_cen      (pix_cen),
        .char_pxl     (char_pxl),
        .scr_pxl      (scr_pxl),
        .obj_pxl      (obj_pxl),
        .layer_en     (layer_en),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .wr           (i_wr.sink),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_n_dly (hblank_n_dly),
        .vblank_n_dly (vblank_n_dly)
    );

endmodule

// ==== logic/palette_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette memory
// 1024 entries of DW bits, write port for the host and a
// registered read port for the pixel pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module palette_ram #(
    parameter int DW = 8              // 8 for red/green, 4 for blue
) (
    input  logic                 clk,
    input  colmix_pkg::pal_idx_t rd_idx,
    output logic [DW-1:0]        q,
    input  colmix_pkg::pal_idx_t wr_idx,
    input  logic [DW-1:0]        wr_data,
    input  logic                 we
);

    logic [DW-1:0] mem [1 << `COLMIX_PAL_AW];

    // host side
    always_ff @(posedge clk) begin
        if (we)
            mem[wr_idx] <= wr_data;
    end

    // pixel side, every clk so q is ready by the next pix_cen
    always_ff @(posedge clk) begin
        q <= mem[rd_idx];
    end

endmodule

// ==== logic/prio_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// priority table, 256 x 4
// host-loaded rule, read registered on every clk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module prio_table (
    input  logic                   clk,
    input  colmix_pkg::prio_addr_t addr,
    output colmix_pkg::prio_sel_t  sel,
    input  colmix_pkg::prio_addr_t wr_addr,
    input  colmix_pkg::prio_sel_t  wr_data,
    input  logic                   we
);

    colmix_pkg::prio_sel_t mem [1 << `COLMIX_PRIO_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[wr_addr] <= wr_data;     // host port
        sel <= mem[addr];                // lookup, no clock enable
    end

endmodule

// ==== verif/colmix_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer properties
// blanking, APB error timing and reset state on the top-level ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module colmix_props (
    input logic                clk,
    input logic                rst_n,
    input logic                psel,
    input logic                penable,
    input logic                pslverr,
    input colmix_pkg::color4_t red,
    input colmix_pkg::color4_t green,
    input colmix_pkg::color4_t blue,
    input logic                vblank_n_dly
);

    // vertical blank leaves as black
    vblank_black: assert property (@(posedge clk) disable iff (!rst_n)
        !vblank_n_dly |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
        else $error("colour output not black during vertical blanking");

    // error only in the cycle right after a setup phase
    slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && $past(psel && !penable)))
        else $error("pslverr raised outside an access phase");

    reset_black: assert property (@(posedge clk)
        !rst_n |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
        else $error("colour output not black in reset");

endmodule

bind colmix_top colmix_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pslverr      (pslverr),
    .red          (red),
    .green        (green),
    .blue         (blue),
    .vblank_n_dly (vblank_n_dly)
);

// ==== verif/colmix_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer testbench
// loads palette and priority table over APB, then streams directed
// and LFSR pixels against a model of the priority rule and palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "colmix_settings.svh"

module colmix_tb;

    localparam int APB_TIMEOUT = 16;                 // clks to wait for pready
    localparam int DEPTH       = `COLMIX_PIPE_DEPTH;
    localparam int N_STIM      = 14;

    typedef struct packed {
        colmix_pkg::char_pxl_t chr;
        colmix_pkg::scr_pxl_t  scr;
        colmix_pkg::obj_pxl_t  obj;
        logic                  hb;
        logic                  vb;
        colmix_pkg::layer_en_t en;
        logic [1:0]            lay;                  // expected winner, 3 char 2 scr 1 obj
    } stim_t;

    logic clk, rst_n, psel, penable, pwrite, pready, pslverr;
    logic pix_cen, hblank_n, vblank_n, hblank_n_dly, vblank_n_dly;
    logic [`COLMIX_DATA_W-1:0] pwdata, prdata;
    colmix_pkg::reg_addr_t     paddr;
    colmix_pkg::char_pxl_t     char_pxl;
    colmix_pkg::scr_pxl_t      scr_pxl;
    colmix_pkg::obj_pxl_t      obj_pxl;
    colmix_pkg::color4_t       red, green, blue;

    int                    n_checks = 0;
    int                    n_errors = 0;
    logic [15:0]           lfsr = 16'd57;
    colmix_pkg::layer_en_t cur_en;
    logic [13:0]           pend [$];                 // {h, v, rgb} still in flight
    logic [7:0]            rd;
    logic                  err;
    stim_t                 rs;

    // priority, opacity, enables and blanking
    stim_t stim [N_STIM] = '{
        '{7'h05, 8'h12, 7'h20, 1'b1, 1'b1, 3'b111, 2'd3},   // all opaque, char on top
        '{7'h07, 8'h34, 7'h2A, 1'b1, 1'b1, 3'b111, 2'd1},   // char clear, bank 2
        '{7'h03, 8'h45, 7'h0F, 1'b1, 1'b1, 3'b111, 2'd2},   // only scroll, bank 3
        '{7'h0B, 8'h65, 7'h1F, 1'b1, 1'b1, 3'b111, 2'd0},   // scroll prio wraps to 0
        '{7'h03, 8'h92, 7'h0F, 1'b1, 1'b1, 3'b111, 2'd0},   // bit 7 kills scroll
        '{7'h03, 8'h92, 7'h33, 1'b1, 1'b1, 3'b111, 2'd1},
        '{7'h05, 8'h12, 7'h2A, 1'b1, 1'b1, 3'b110, 2'd1},   // char disabled
        '{7'h05, 8'h21, 7'h2A, 1'b1, 1'b1, 3'b010, 2'd2},   // scroll only enabled
        '{7'h05, 8'h21, 7'h2A, 1'b1, 1'b1, 3'b000, 2'd0},   // nothing enabled, index 0
        '{7'h06, 8'h21, 7'h2A, 1'b1, 1'b1, 3'b001, 2'd3},
        '{7'h05, 8'h12, 7'h20, 1'b0, 1'b1, 3'b111, 2'd3},   // hblank
        '{7'h05, 8'h12, 7'h20, 1'b1, 1'b0, 3'b111, 2'd3},   // vblank
        '{7'h11, 8'h5A, 7'h10, 1'b1, 1'b1, 3'b111, 2'd3},
        '{7'h7F, 8'h7F, 7'h7F, 1'b1, 1'b1, 3'b111, 2'd0}
    };

    colmix_top i_colmix_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                        // 4 ns period
    end

    function automatic logic [1:0] scr_prio(input colmix_pkg::scr_pxl_t s,
                                            input colmix_pkg::layer_en_t en);
        if (s[7] || !en[1])
            return 2'd0;
        else
            return s[6:5] + 2'd1;                     // 3 wraps to 0
    endfunction

    // char over object over scroll, scroll needs a nonzero priority
    function automatic logic [1:0] layer_of(input logic c_opq, input logic o_opq,
                                            input logic [1:0] prio);
        return c_opq ? 2'd3 : o_opq ? 2'd1 : (prio != 2'd0) ? 2'd2 : 2'd0;
    endfunction

    function automatic logic [3:0] prio_entry(input logic [7:0] a);
        return {a[5:4], layer_of(a[7], a[6], a[5:4])};   // bank = scroll prio
    endfunction

    function automatic logic [1:0] pick_layer(input stim_t s);
        return layer_of(s.chr[1:0] != 2'b11 && s.en[0], s.obj[3:0] != 4'hf && s.en[2],
                        scr_prio(s.scr, s.en));
    endfunction

    // palette holds red = idx[3:0], green = idx[7:4], blue = idx[9:6]
    function automatic logic [13:0] exp_word(input stim_t s);
        colmix_pkg::scr_pxl_t code;
        colmix_pkg::pal_idx_t idx;
        case (s.lay)
            2'd3:    code = colmix_pkg::scr_pxl_t'(s.chr);
            2'd2:    code = s.scr;
            2'd1:    code = colmix_pkg::scr_pxl_t'(s.obj);
            default: code = '0;
        endcase
        idx = {scr_prio(s.scr, s.en), code};
        if (!s.hb || !s.vb)
            return {s.hb, s.vb, 12'd0};
        else
            return {s.hb, s.vb, idx[3:0], idx[7:4], idx[9:6]};
    endfunction

    // galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic apb_xfer(input colmix_pkg::reg_addr_t addr, input logic write,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output logic slverr);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;                              // setup phase
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: APB transfer to %h never completed", addr);
            $display("sim failed");
            $finish;
        end else begin
            rdata  = prdata;                          // sampled mid-cycle, stable
            slverr = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input colmix_pkg::reg_addr_t addr, input logic [7:0] data,
                             input logic exp_err);
        logic [7:0] unused_rd;
        logic       e;
        apb_xfer(addr, 1'b1, data, unused_rd, e);
        assert (e == exp_err) else begin
            n_errors++;
            $display("error: %0t ns write to %h pslverr %b, expected %b", $time, addr, e, exp_err);
        end
    endtask

    task automatic apb_read(input colmix_pkg::reg_addr_t addr, output logic [7:0] rdata,
                            output logic e);
        apb_xfer(addr, 1'b0, 8'h00, rdata, e);
    endtask

    // one pixel period: drive on the idle edge, check mid-cycle, pix_cen drops after capture
    task automatic pixel_step(input stim_t s);
        logic [13:0] exp;
        logic [13:0] got;
        if (s.en != cur_en) begin
            apb_write(`COLMIX_CTRL_ADDR, {5'd0, s.en}, 1'b0);
            cur_en = s.en;
        end
        @(posedge clk);
        pix_cen  <= 1'b1;
        char_pxl <= s.chr;
        scr_pxl  <= s.scr;
        obj_pxl  <= s.obj;
        hblank_n <= s.hb;
        vblank_n <= s.vb;
        pend.push_back(exp_word(s));
        @(negedge clk);
        if (pend.size() > DEPTH) begin                // output shows the sample DEPTH back
            exp = pend.pop_front();
            got = {hblank_n_dly, vblank_n_dly, red, green, blue};
            n_checks++;
            assert (got == exp) else begin
                n_errors++;
                $display("error: %0t ns pixel check %0d got %h, expected %h",
                         $time, n_checks, got, exp);
            end
        end
        @(posedge clk);
        pix_cen <= 1'b0;
    endtask

    initial begin
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pix_cen  = 1'b0;
        char_pxl = '0;
        scr_pxl  = '0;
        obj_pxl  = '0;
        hblank_n = 1'b1;
        vblank_n = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // control register and error responses
        apb_write(`COLMIX_CTRL_ADDR, 8'h05, 1'b0);
        apb_read(`COLMIX_CTRL_ADDR, rd, err);
        assert (rd == 8'h05 && !err) else begin
            n_errors++;
            $display("error: %0t ns ctrl read %h pslverr %b, expected 05 and 0", $time, rd, err);
        end
        apb_read(`COLMIX_RG_BASE + 12'h010, rd, err);
        assert (rd == 8'h00 && err) else begin
            n_errors++;
            $display("error: %0t ns palette read %h pslverr %b, expected 00 and 1", $time, rd, err);
        end
        apb_write(12'hF00, 8'h5A, 1'b1);              // hole in the map
        apb_write(`COLMIX_CTRL_ADDR, 8'h07, 1'b0);
        cur_en = 3'b111;

        for (int a = 0; a < (1 << `COLMIX_PAL_AW); a++) begin
            apb_write(`COLMIX_RG_BASE + colmix_pkg::reg_addr_t'(a), {a[3:0], a[7:4]}, 1'b0);
            apb_write(`COLMIX_B_BASE + colmix_pkg::reg_addr_t'(a), {4'd0, a[9:6]}, 1'b0);
        end
        for (int a = 0; a < (1 << `COLMIX_PRIO_AW); a++)
            apb_write(`COLMIX_PRIO_BASE + colmix_pkg::reg_addr_t'(a),
                      {4'd0, prio_entry(a[7:0])}, 1'b0);

        foreach (stim[i])
            pixel_step(stim[i]);

        repeat (200) begin
            rs.en  = colmix_pkg::layer_en_t'(rand_bits(3));
            rs.chr = colmix_pkg::char_pxl_t'(rand_bits(`COLMIX_CHAR_W));
            rs.scr = colmix_pkg::scr_pxl_t'(rand_bits(`COLMIX_SCR_W));
            rs.obj = colmix_pkg::obj_pxl_t'(rand_bits(`COLMIX_OBJ_W));
            rs.hb  = 1'b1;
            rs.vb  = 1'b1;
            rs.lay = pick_layer(rs);
            pixel_step(rs);
        end
        repeat (DEPTH) pixel_step(stim[0]);           // push the last samples out

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
